//--- frontend_top.f
hdl/cpu_params.sv
hdl/bp_pkg.sv
hdl/if1_stage.sv
hdl/gshare.sv
hdl/btb.sv
hdl/frontend_top.sv
tb/frontend_checker.sv
tb/frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module frontend_tb \
    -f frontend_top.f \
    --Mdir obj_dir -o frontend_sim

./obj_dir/frontend_sim | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb/frontend_tb.sv
module frontend_tb
import cpu_params::*;
();

    localparam int PHT_BITS = 8;
    localparam int BTB_BITS = 6;
    localparam int OFS = 3; // byte offset bits of an 8-byte block.
    localparam int TAG_LSB = OFS + BTB_BITS;
    localparam int LIMIT = 2000;

    logic clk;
    logic prev_rst;
    logic backend_flush;
    logic [31:0] backend_redirect_pc;
    logic cb_update;
    logic [31:0] cb_pc;
    logic cb_taken;
    logic [31:0] cb_target;
    logic icache_req;
    logic [31:0] icache_addr;
    logic icache_resp;
    logic [IF_WIDTH-1:0][31:0] icache_rdata;
    logic fifo_valid;
    logic fifo_ready;
    logic [31:0] fifo_pc;
    logic [IF_WIDTH-1:0][31:0] fifo_insts;
    logic [ID_WIDTH-1:0] fifo_slot_valid;
    logic fifo_predict_taken;
    logic [31:0] fifo_predict_target;

    integer seed = 32'hc1a8_acf1;
    int errors = 0;
    int checks = 0;
    int xfer_count = 0;
    logic rand_ready = 1'b0;
    logic [31:0] exp_pc = RESET_PC;
    logic [31:0] xfer_pc [$];
    logic xfer_taken [$];
    logic [ID_WIDTH-1:0] xfer_mask [$];

    // mirrored predictor state.
    logic [PHT_BITS-1:0] ghr_m;
    logic [1:0] pht_m [1 << PHT_BITS];
    logic btb_v [1 << BTB_BITS];
    logic [31-TAG_LSB:0] btb_tag [1 << BTB_BITS];
    logic [31:0] btb_tgt [1 << BTB_BITS];

    frontend_top #(.PHT_INDEX_BITS(PHT_BITS), .BTB_INDEX_BITS(BTB_BITS)) u_frontend_top (.*);

    always #4 clk = ~clk;

    function automatic void ref_block(input logic [31:0] pc, output logic [31:0] addr,
                                      output logic [IF_WIDTH-1:0][31:0] insts,
                                      output logic [ID_WIDTH-1:0] mask,
                                      output logic taken, output logic [31:0] next);
        logic [PHT_BITS-1:0] idx;
        logic [BTB_BITS-1:0] bidx;
        logic hit;
        addr = {pc[31:OFS], 3'b000};
        for (int i = 0; i < IF_WIDTH; i++) begin
            insts[i] = (addr + 32'(4 * i)) ^ 32'h5a5a0000;
            mask[i] = (i >= int'(pc[OFS-1:2]));
        end
        idx = pc[OFS +: PHT_BITS] ^ ghr_m;
        taken = pht_m[idx][1];
        bidx = pc[OFS +: BTB_BITS];
        hit = btb_v[bidx] && btb_tag[bidx] == pc[31:TAG_LSB];
        next = (taken && hit) ? btb_tgt[bidx] : addr + 32'd8;
    endfunction

    task automatic compare_addr(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_block(input logic [IF_WIDTH-1:0][31:0] exp,
                                 input logic [IF_WIDTH-1:0][31:0] got);
        for (int i = 0; i < IF_WIDTH; i++) begin
            compare_addr($sformatf("fifo_insts[%0d]", i), exp[i], got[i]);
        end
    endtask

    task automatic compare_mask(input string name, input logic [ID_WIDTH-1:0] exp,
                                input logic [ID_WIDTH-1:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // compare every transfer, then follow flushes and training.
    always @(posedge clk) begin
        logic [31:0] e_addr;
        logic [IF_WIDTH-1:0][31:0] e_insts;
        logic [ID_WIDTH-1:0] e_mask;
        logic e_taken;
        logic [31:0] e_next;
        logic [PHT_BITS-1:0] idx;
        if (!prev_rst) begin
            if (fifo_valid && fifo_ready) begin
                ref_block(exp_pc, e_addr, e_insts, e_mask, e_taken, e_next);
                compare_addr("fifo_pc", e_addr, fifo_pc);
                compare_block(e_insts, fifo_insts);
                compare_mask("fifo_slot_valid", e_mask, fifo_slot_valid);
                compare_bit("fifo_predict_taken", e_taken, fifo_predict_taken);
                compare_addr("fifo_predict_target", e_next, fifo_predict_target);
                xfer_pc.push_back(fifo_pc);
                xfer_taken.push_back(fifo_predict_taken);
                xfer_mask.push_back(fifo_slot_valid);
                exp_pc = e_next;
                xfer_count++;
            end
            if (backend_flush) begin
                exp_pc = backend_redirect_pc;
            end
            if (cb_update) begin
                idx = cb_pc[OFS +: PHT_BITS] ^ ghr_m;
                if (cb_taken && pht_m[idx] != 2'd3) pht_m[idx] = pht_m[idx] + 2'd1;
                if (!cb_taken && pht_m[idx] != 2'd0) pht_m[idx] = pht_m[idx] - 2'd1;
                ghr_m = {ghr_m[PHT_BITS-2:0], cb_taken};
                if (cb_taken) begin
                    btb_v[cb_pc[OFS +: BTB_BITS]] = 1'b1;
                    btb_tag[cb_pc[OFS +: BTB_BITS]] = cb_pc[31:TAG_LSB];
                    btb_tgt[cb_pc[OFS +: BTB_BITS]] = cb_target;
                end
            end
        end
    end

    // one request at a time with 1 to 4 cycles of delay.
    always @(negedge clk) begin
        static logic busy = 1'b0;
        static int cnt = 0;
        static logic [31:0] addr = '0;
        icache_resp = 1'b0;
        if (busy) begin
            if (cnt == 1) begin
                for (int i = 0; i < IF_WIDTH; i++) begin
                    icache_rdata[i] = (addr + 32'(4 * i)) ^ 32'h5a5a0000;
                end
                icache_resp = 1'b1;
                busy = 1'b0;
            end else begin
                cnt--;
            end
        end else if (icache_req && !prev_rst) begin
            addr = icache_addr;
            cnt = 1 + int'($unsigned($random(seed)) % 4);
            busy = 1'b1;
        end
    end

    always @(negedge clk) begin
        logic [31:0] rnd;
        if (rand_ready) begin
            rnd = $random(seed);
            fifo_ready = rnd[0];
        end
    end

    task automatic abort_run(input string what);
        $display("timeout waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic wait_transfers(input int n);
        int target;
        int cycles;
        target = xfer_count + n;
        cycles = 0;
        while (xfer_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("fifo transfers");
        end
    endtask

    task automatic wait_req_low();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (icache_req) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) abort_run("icache_req to drop");
        end
    endtask

    task automatic train(input logic [31:0] pc, input logic taken, input logic [31:0] target);
        @(negedge clk);
        cb_update = 1'b1;
        cb_pc = pc;
        cb_taken = taken;
        cb_target = target;
        @(negedge clk);
        cb_update = 1'b0;
    endtask

    task automatic flush_to(input logic [31:0] pc);
        @(negedge clk);
        fifo_ready = 1'b0;
        backend_flush = 1'b1;
        backend_redirect_pc = pc;
        @(negedge clk);
        backend_flush = 1'b0;
        fifo_ready = 1'b1;
    endtask

    task automatic report_test(input string name, input int err_before);
        string verdict;
        if (errors == err_before) begin
            verdict = "ok";
        end else begin
            verdict = "failed";
        end
        $display("%s: %s (%0d errors)", name, verdict, errors - err_before);
    endtask

    initial begin
        int e0;
        int n0;
        clk = 1'b0;
        prev_rst = 1'b1;
        backend_flush = 1'b0;
        backend_redirect_pc = '0;
        cb_update = 1'b0;
        cb_pc = '0;
        cb_taken = 1'b0;
        cb_target = '0;
        icache_resp = 1'b0;
        icache_rdata = '0;
        fifo_ready = 1'b1;
        ghr_m = '0;
        for (int i = 0; i < (1 << PHT_BITS); i++) pht_m[i] = 2'd1;
        for (int i = 0; i < (1 << BTB_BITS); i++) btb_v[i] = 1'b0;
        repeat (16) @(negedge clk);
        prev_rst = 1'b0;

        e0 = errors;
        n0 = xfer_count;
        wait_transfers(6);
        compare_addr("first fifo_pc", RESET_PC, xfer_pc[n0]);
        compare_mask("first fifo_slot_valid", '1, xfer_mask[n0]);
        report_test("test 1 reset and sequential fetch", e0);

        e0 = errors;
        rand_ready = 1'b1;
        wait_transfers(40);
        rand_ready = 1'b0;
        @(negedge clk);
        fifo_ready = 1'b1;
        report_test("test 2 random back-pressure", e0);

        e0 = errors;
        wait_req_low();
        flush_to(RESET_PC + 32'h204); // lands mid-block just as a new request goes out.
        n0 = xfer_count;
        wait_transfers(3);
        compare_addr("flush fifo_pc", RESET_PC + 32'h200, xfer_pc[n0]);
        compare_mask("flush fifo_slot_valid", 2'b10, xfer_mask[n0]);
        report_test("test 3 mid-block flush", e0);

        e0 = errors;
        fifo_ready = 1'b0;
        for (int i = 0; i < 12; i++) train(RESET_PC + 32'h40, 1'b1, RESET_PC + 32'h800);
        n0 = xfer_count;
        flush_to(RESET_PC + 32'h40);
        wait_transfers(2);
        compare_bit("trained fifo_predict_taken", 1'b1, xfer_taken[n0]);
        compare_addr("trained next fifo_pc", RESET_PC + 32'h800, xfer_pc[n0 + 1]);
        report_test("test 4 taken training", e0);

        // the btb entry from test 4 still hits here.
        e0 = errors;
        fifo_ready = 1'b0;
        for (int i = 0; i < 12; i++) train(RESET_PC + 32'h40, 1'b0, RESET_PC + 32'h900);
        n0 = xfer_count;
        flush_to(RESET_PC + 32'h40);
        wait_transfers(2);
        compare_bit("not-taken fifo_predict_taken", 1'b0, xfer_taken[n0]);
        compare_addr("fall-through fifo_pc", RESET_PC + 32'h48, xfer_pc[n0 + 1]);
        report_test("test 5 not-taken training", e0);

        $display("checks %0d, errors %0d, transfers %0d", checks, errors, xfer_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb/frontend_checker.sv
module frontend_checker
import cpu_params::*;
(
    input logic                      clk,
    input logic                      prev_rst,
    input logic                      backend_flush,
    input logic                      icache_req,
    input logic [31:0]               icache_addr,
    input logic                      icache_resp,
    input logic                      fifo_valid,
    input logic                      fifo_ready,
    input logic [31:0]               fifo_pc,
    input logic [IF_WIDTH-1:0][31:0] fifo_insts,
    input logic [ID_WIDTH-1:0]       fifo_slot_valid
);

    // a flush may drop the held block.
    fifo_hold_a: assert property (@(posedge clk) disable iff (prev_rst)
        fifo_valid && !fifo_ready && !backend_flush |=>
            fifo_valid && $stable(fifo_pc) && $stable(fifo_insts) && $stable(fifo_slot_valid))
        else $error("fifo payload changed or valid dropped before ready");

    req_align_a: assert property (@(posedge clk) disable iff (prev_rst)
        icache_req |-> (icache_addr & ~IF_BLK_MASK) == 32'd0)
        else $error("icache_addr not block aligned");

    req_hold_a: assert property (@(posedge clk) disable iff (prev_rst)
        icache_req && !icache_resp |=> icache_req && $stable(icache_addr))
        else $error("icache_req or icache_addr changed before the response");

    reset_idle_a: assert property (@(posedge clk)
        prev_rst |=> !fifo_valid && !icache_req)
        else $error("fifo_valid or icache_req high after reset");

endmodule

bind frontend_top frontend_checker u_frontend_checker (
    .clk             (clk),
    .prev_rst        (prev_rst),
    .backend_flush   (backend_flush),
    .icache_req      (icache_req),
    .icache_addr     (icache_addr),
    .icache_resp     (icache_resp),
    .fifo_valid      (fifo_valid),
    .fifo_ready      (fifo_ready),
    .fifo_pc         (fifo_pc),
    .fifo_insts      (fifo_insts),
    .fifo_slot_valid (fifo_slot_valid)
);

//--- hdl/frontend_top.sv
module frontend_top
import cpu_params::*;
#(
    parameter int unsigned PHT_INDEX_BITS = 8,
    parameter int unsigned BTB_INDEX_BITS = 6
)
(
    input  logic                      clk,
    input  logic                      prev_rst,

    input  logic                      backend_flush,
    input  logic [31:0]               backend_redirect_pc,

    input  logic                      cb_update,
    input  logic [31:0]               cb_pc,
    input  logic                      cb_taken,
    input  logic [31:0]               cb_target,

    output logic                      icache_req,
    output logic [31:0]               icache_addr,
    input  logic                      icache_resp,
    input  logic [IF_WIDTH-1:0][31:0] icache_rdata,

    output logic                      fifo_valid,
    input  logic                      fifo_ready,
    output logic [31:0]               fifo_pc,
    output logic [IF_WIDTH-1:0][31:0] fifo_insts,
    output logic [ID_WIDTH-1:0]       fifo_slot_valid,
    output logic                      fifo_predict_taken,
    output logic [31:0]               fifo_predict_target
);

    logic        rst_d;  // high for the first cycle out of reset.
    logic [31:0] pc_next;
    logic [31:0] pc;
    logic [31:0] word_ofs;
    logic        predict_taken;
    logic [31:0] predict_target;

    always_ff @(posedge clk) begin
        rst_d <= prev_rst;
    end

    always_comb begin
        if (rst_d) begin
            pc_next = RESET_PC;
        end else if (backend_flush) begin
            pc_next = backend_redirect_pc;
        end else begin
            pc_next = predict_target;
        end
    end

    if1_stage u_if1_stage (
        .clk          (clk),
        .prev_rst     (prev_rst),
        .flush        (backend_flush),
        .pc_next      (pc_next),
        .pc           (pc),
        .icache_req   (icache_req),
        .icache_addr  (icache_addr),
        .icache_resp  (icache_resp),
        .icache_rdata (icache_rdata),
        .nxt_valid    (fifo_valid),
        .nxt_ready    (fifo_ready),
        .insts        (fifo_insts)
    );

    gshare #(
        .PHT_INDEX_BITS (PHT_INDEX_BITS)
    ) u_gshare (
        .clk           (clk),
        .prev_rst      (prev_rst),
        .pc            (pc),
        .cb_update     (cb_update),
        .cb_pc         (cb_pc),
        .cb_taken      (cb_taken),
        .predict_taken (predict_taken)
    );

    btb #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .clk            (clk),
        .prev_rst       (prev_rst),
        .pc             (pc),
        .predict_taken  (predict_taken),
        .cb_update      (cb_update),
        .cb_pc          (cb_pc),
        .cb_taken       (cb_taken),
        .cb_target      (cb_target),
        .predict_target (predict_target)
    );

    assign fifo_pc             = pc & IF_BLK_MASK;
    assign fifo_predict_taken  = predict_taken;
    assign fifo_predict_target = predict_target;

    // slots below the entry word of a redirect are dead.
    assign word_ofs = (pc & ~IF_BLK_MASK) >> 2;

    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            fifo_slot_valid[i] = (32'(i) >= word_ofs);
        end
    end

endmodule

//--- hdl/btb.sv
module btb
import cpu_params::*;
#(
    parameter int unsigned BTB_INDEX_BITS = 6
)
(
    input  logic        clk,
    input  logic        prev_rst,

    input  logic [31:0] pc,
    input  logic        predict_taken,

    input  logic        cb_update,
    input  logic [31:0] cb_pc,
    input  logic        cb_taken,
    input  logic [31:0] cb_target,

    output logic [31:0] predict_target
);

    localparam int unsigned BTB_SIZE = 1 << BTB_INDEX_BITS;
    localparam int unsigned TAG_LSB  = IF_OFS_BITS + BTB_INDEX_BITS;
    localparam int unsigned TAG_BITS = 32 - TAG_LSB;

    logic [BTB_SIZE-1:0] valid_q;
    logic [TAG_BITS-1:0] tag_q    [BTB_SIZE];
    logic [31:0]         target_q [BTB_SIZE];

    logic [BTB_INDEX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0]       rd_tag;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]       wr_tag;
    logic                      hit;
    logic [31:0]               fall_through;

    assign rd_idx = pc[IF_OFS_BITS +: BTB_INDEX_BITS];
    assign rd_tag = pc[TAG_LSB +: TAG_BITS];
    assign wr_idx = cb_pc[IF_OFS_BITS +: BTB_INDEX_BITS];
    assign wr_tag = cb_pc[TAG_LSB +: TAG_BITS];

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            valid_q <= '0;
        end else if (cb_update && cb_taken) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // only taken branches allocate.
    always_ff @(posedge clk) begin
        if (cb_update && cb_taken) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= cb_target;
        end
    end

    assign hit          = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign fall_through = (pc & IF_BLK_MASK) + 32'(IF_BLK_SIZE); // next sequential block.

    always_comb begin
        if (predict_taken && hit) begin
            predict_target = target_q[rd_idx];
        end else begin
            predict_target = fall_through;
        end
    end

endmodule

//--- hdl/gshare.sv
module gshare
import cpu_params::*;
import bp_pkg::*;
#(
    parameter int unsigned PHT_INDEX_BITS = 8
)
(
    input  logic        clk,
    input  logic        prev_rst,

    input  logic [31:0] pc,

    input  logic        cb_update,
    input  logic [31:0] cb_pc,
    input  logic        cb_taken,

    output logic        predict_taken
);

    localparam int unsigned PHT_SIZE = 1 << PHT_INDEX_BITS;

    logic [PHT_INDEX_BITS-1:0] ghr; // global history, newest in bit 0.
    logic [CTR_BITS-1:0]       pht [PHT_SIZE];

    logic [PHT_INDEX_BITS-1:0] lookup_idx;
    logic [PHT_INDEX_BITS-1:0] update_idx;

    assign lookup_idx = pc[IF_OFS_BITS +: PHT_INDEX_BITS] ^ ghr;

    // trained at the index seen before this outcome is shifted in
    assign update_idx = cb_pc[IF_OFS_BITS +: PHT_INDEX_BITS] ^ ghr;

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            ghr <= '0;
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht[i] <= CTR_RESET;
            end
        end else if (cb_update) begin
            ghr             <= PHT_INDEX_BITS'({ghr, cb_taken});
            pht[update_idx] <= ctr_next(pht[update_idx], cb_taken);
        end
    end

    assign predict_taken = ctr_taken(pht[lookup_idx]);

endmodule

//--- hdl/if1_stage.sv
module if1_stage
import cpu_params::*;
(
    input  logic                      clk,
    input  logic                      prev_rst,

    input  logic                      flush,
    input  logic [31:0]               pc_next,
    output logic [31:0]               pc,

    output logic                      icache_req,
    output logic [31:0]               icache_addr,
    input  logic                      icache_resp,
    input  logic [IF_WIDTH-1:0][31:0] icache_rdata,

    output logic                      nxt_valid,
    input  logic                      nxt_ready,
    output logic [IF_WIDTH-1:0][31:0] insts
);

    localparam logic [1:0] S_REQ  = 2'd0; // first load after reset.
    localparam logic [1:0] S_WAIT = 2'd1; // request outstanding.
    localparam logic [1:0] S_HOLD = 2'd2; // block offered downstream.

    logic [1:0]  state;
    logic        discard;  // pending response belongs to a flushed pc.
    logic [31:0] req_addr;

    logic        load_pc;
    logic        start;
    logic        retry;
    logic        accept;

    assign load_pc = (state == S_REQ) || flush || (state == S_HOLD && nxt_ready);

    // new request from pc_next
    assign start = (state == S_REQ)
                || (state == S_HOLD && (flush || nxt_ready))
                || (state == S_WAIT && icache_resp && flush);

    // stale response done, reissue for the redirected pc
    assign retry  = (state == S_WAIT) && icache_resp && discard && !flush;
    assign accept = (state == S_WAIT) && icache_resp && !discard && !flush;

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            state   <= S_REQ;
            discard <= 1'b0;
            pc      <= RESET_PC;
        end else begin
            if (load_pc) begin
                pc <= pc_next;
            end
            case (state)
                S_REQ: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (icache_resp) begin
                        discard <= 1'b0;
                        if (accept) begin
                            state <= S_HOLD;
                        end
                    end else if (flush) begin
                        discard <= 1'b1;
                    end
                end
                S_HOLD: begin
                    if (flush || nxt_ready) begin
                        state <= S_WAIT;
                    end
                end
                default: begin
                    state <= S_REQ;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= pc_next & IF_BLK_MASK;
        end else if (retry) begin
            req_addr <= pc & IF_BLK_MASK;
        end
        if (accept) begin
            insts <= icache_rdata;
        end
    end

    assign icache_req  = (state == S_WAIT);
    assign icache_addr = req_addr;
    assign nxt_valid   = (state == S_HOLD);

endmodule

//--- hdl/bp_pkg.sv
package bp_pkg;

    localparam int unsigned CTR_BITS = 2;

    localparam logic [CTR_BITS-1:0] CTR_SNT = 2'd0; // strong not-taken.
    localparam logic [CTR_BITS-1:0] CTR_WNT = 2'd1; // weak not-taken.
    localparam logic [CTR_BITS-1:0] CTR_WT  = 2'd2; // weak taken.
    localparam logic [CTR_BITS-1:0] CTR_ST  = 2'd3; // strong taken.

    localparam logic [CTR_BITS-1:0] CTR_RESET = CTR_WNT;

    // weak taken and above, i.e. upper bit set
    function automatic logic ctr_taken(input logic [CTR_BITS-1:0] ctr);
        return ctr >= CTR_WT;
    endfunction

    function automatic logic [CTR_BITS-1:0] ctr_next(input logic [CTR_BITS-1:0] ctr,
                                                     input logic taken);
        logic [CTR_BITS-1:0] res;
        res = ctr;
        if (taken && ctr != CTR_ST) begin
            res = ctr + 1'b1;
        end else if (!taken && ctr != CTR_SNT) begin
            res = ctr - 1'b1;
        end
        return res;
    endfunction

endpackage

//--- hdl/cpu_params.sv
package cpu_params;

    localparam int unsigned IF_WIDTH = 2; // instructions per fetch block.

    localparam int unsigned ID_WIDTH = IF_WIDTH;

    localparam int unsigned IF_BLK_SIZE = IF_WIDTH * 4; // bytes per block.

    // byte offset bits inside a block
    localparam int unsigned IF_OFS_BITS = $clog2(IF_BLK_SIZE);

    localparam logic [31:0] IF_BLK_MASK = ~(32'(IF_BLK_SIZE) - 32'd1);

    localparam logic [31:0] RESET_PC = 32'h1eceb000;

endpackage
